//--- vlog.f
rv_core_pkg.sv
rv_regfile.sv
rv_fetch.sv
rv_decode.sv
rv_execute.sv
rv_mem_access.sv
rv_hazard_unit.sv
rv_core.sv
tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - rv_core_pkg.sv
  - rv_regfile.sv
  - rv_fetch.sv
  - rv_decode.sv
  - rv_execute.sv
  - rv_mem_access.sv
  - rv_hazard_unit.sv
  - rv_core.sv
  - target: simulation
    files:
      - tb_rv_core.sv

//--- tb_rv_core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for rv_core: program builder, bus memories,
// reference ISA model, store monitor
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tb_rv_core;
    import rv_core_pkg::*;

    localparam word_t RESET_PC = 32'h0;
    localparam int K_REG = 0, K_IMM = 1, K_LUI = 2, K_LOAD = 3;
    localparam int K_STORE = 4, K_BRANCH = 5, K_JAL = 6;

    logic clk, arst_n, iready_n, dready_n, dbusy, dreq, dwrite;
    word_t idata, iaddr, daddr, ioff;
    logic [1:0] dsize;
    wire word_t ddata;

    word_t imem [256];
    word_t dmem [64];
    word_t ref_mem [64];
    int p_kind [64];
    logic [2:0] p_f3 [64];
    logic p_alt [64];
    logic [4:0] p_rd [64], p_rs1 [64], p_rs2 [64];
    word_t p_imm [64];
    int n_prog;
    word_t exp_addr [$], exp_data [$], exp_size [$];
    int n_seen, seed, ihold, dhold, cycles;
    logic random_mode, i_next, d_next, b_next;

    rv_core #(
        .RESET_PC (RESET_PC)
    ) u_rv_core (
        .clk      (clk),
        .arst_n   (arst_n),
        .iready_n (iready_n),
        .idata    (idata),
        .iaddr    (iaddr),
        .dready_n (dready_n),
        .dbusy    (dbusy),
        .daddr    (daddr),
        .dsize    (dsize),
        .dreq     (dreq),
        .dwrite   (dwrite),
        .ddata    (ddata)
    );

    // memories answer combinationally and the strobes pace them
    assign ioff  = iaddr - RESET_PC;
    assign idata = imem[ioff[9:2]];
    assign ddata = (dreq && !dwrite) ? dmem[daddr[7:2]] : 'z;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    function automatic word_t encode(int kind, logic [2:0] f3, logic alt, logic [4:0] rd,
                                     logic [4:0] rs1, logic [4:0] rs2, word_t imm);
        case (kind)
            K_REG:    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OP_REG};
            K_IMM:    return {imm[11:0], rs1, f3, rd, OP_IMM};
            K_LUI:    return {imm[31:12], rd, OP_LUI};
            K_LOAD:   return {imm[11:0], rs1, f3, rd, OP_LOAD};
            K_STORE:  return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
            K_BRANCH: return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
            default:  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
        endcase
    endfunction

    task automatic emit(int kind, logic [2:0] f3, logic alt, logic [4:0] rd,
                        logic [4:0] rs1, logic [4:0] rs2, word_t imm);
        p_kind[n_prog] = kind;
        p_f3[n_prog]   = f3;
        p_alt[n_prog]  = alt;
        p_rd[n_prog]   = rd;
        p_rs1[n_prog]  = rs1;
        p_rs2[n_prog]  = rs2;
        p_imm[n_prog]  = imm;
        imem[n_prog]   = encode(kind, f3, alt, rd, rs1, rs2, imm);
        n_prog++;
    endtask

    task automatic build_program();
        n_prog = 0;
        // dependent ALU chain on the data base in x10
        emit(K_IMM, 3'b000, 0, 10, 0, 0, 64);
        emit(K_IMM, 3'b000, 0, 1, 0, 0, 5);
        emit(K_IMM, 3'b000, 0, 2, 0, 0, -3);
        emit(K_REG, 3'b000, 0, 3, 1, 2, 0);
        emit(K_REG, 3'b000, 1, 4, 3, 1, 0);
        emit(K_IMM, 3'b001, 0, 5, 4, 0, 3);
        emit(K_REG, 3'b100, 0, 6, 5, 3, 0);
        emit(K_REG, 3'b110, 0, 7, 6, 4, 0);
        emit(K_REG, 3'b111, 0, 8, 7, 5, 0);
        emit(K_REG, 3'b010, 0, 9, 2, 1, 0);
        emit(K_IMM, 3'b101, 0, 11, 2, 0, 4);
        emit(K_LUI, 3'b000, 0, 12, 0, 0, 32'h92345000);
        emit(K_IMM, 3'b100, 0, 12, 12, 0, 32'h678);
        emit(K_STORE, 3'b010, 0, 0, 10, 3, 0);
        emit(K_STORE, 3'b010, 0, 0, 10, 4, 4);
        emit(K_STORE, 3'b010, 0, 0, 10, 6, 8);
        emit(K_STORE, 3'b010, 0, 0, 10, 8, 12);
        emit(K_STORE, 3'b010, 0, 0, 10, 9, 16);
        emit(K_STORE, 3'b010, 0, 0, 10, 11, 20);
        emit(K_STORE, 3'b010, 0, 0, 10, 12, 24);
        emit(K_STORE, 3'b010, 0, 0, 10, 5, 28);
        // load-use pair and the bytes of the x12 word
        emit(K_LOAD, 3'b010, 0, 13, 10, 0, 0);
        emit(K_REG, 3'b000, 0, 14, 13, 13, 0);
        emit(K_STORE, 3'b010, 0, 0, 10, 14, 32);
        for (int k = 0; k < 4; k++) begin
            emit(K_LOAD, 3'b100, 0, 15, 10, 0, 24 + k);
            emit(K_STORE, 3'b000, 0, 0, 10, 15, 36 + k);
        end
        emit(K_LOAD, 3'b010, 0, 16, 10, 0, 36);
        emit(K_STORE, 3'b010, 0, 0, 10, 16, 40);
        emit(K_LOAD, 3'b100, 0, 17, 0, 0, 2);
        emit(K_STORE, 3'b010, 0, 0, 10, 17, 44);
        // counted loop, forward beq, jal link
        emit(K_IMM, 3'b000, 0, 20, 0, 0, 0);
        emit(K_IMM, 3'b000, 0, 21, 0, 0, 4);
        emit(K_IMM, 3'b000, 0, 20, 20, 0, 3);
        emit(K_IMM, 3'b000, 0, 21, 21, 0, -1);
        emit(K_BRANCH, 3'b001, 0, 0, 21, 0, -8);
        emit(K_IMM, 3'b000, 0, 22, 0, 0, 99);
        emit(K_STORE, 3'b010, 0, 0, 10, 20, 48);
        emit(K_BRANCH, 3'b000, 0, 0, 20, 20, 12);
        emit(K_STORE, 3'b010, 0, 0, 10, 0, 52);
        emit(K_IMM, 3'b000, 0, 20, 0, 0, 7);
        emit(K_JAL, 3'b000, 0, 23, 0, 0, 8);
        emit(K_STORE, 3'b010, 0, 0, 10, 0, 60);
        emit(K_STORE, 3'b010, 0, 0, 10, 23, 56);
        emit(K_STORE, 3'b010, 0, 0, 10, 22, 60);
        // jump to self ends the program
        emit(K_JAL, 3'b000, 0, 0, 0, 0, 0);
    endtask

    function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic void ref_run();
        word_t regs [32];
        word_t a, b, res, addr;
        logic [7:0] bt;
        logic wr;
        int pc, next, steps;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        exp_addr.delete();
        exp_data.delete();
        exp_size.delete();
        pc = 0;
        steps = 0;
        while (steps < 2000 && !(p_kind[pc] == K_JAL && p_imm[pc] == '0)) begin
            a    = regs[p_rs1[pc]];
            b    = regs[p_rs2[pc]];
            addr = a + p_imm[pc];
            next = pc + 1;
            wr   = 1'b1;
            res  = '0;
            case (p_kind[pc])
                K_REG: res = alu_ref(p_f3[pc], p_alt[pc], a, b);
                K_IMM: res = alu_ref(p_f3[pc], 1'b0, a, p_imm[pc]);
                K_LUI: res = p_imm[pc];
                K_LOAD: begin
                    res = ref_mem[addr[7:2]];
                    if (p_f3[pc] == 3'b100) begin
                        res = {24'b0, res[addr[1:0] * 8 +: 8]};
                    end
                end
                K_STORE: begin
                    wr = 1'b0;
                    exp_addr.push_back(addr);
                    if (p_f3[pc] == 3'b000) begin
                        bt = b[7:0];
                        ref_mem[addr[7:2]][addr[1:0] * 8 +: 8] = bt;
                        exp_data.push_back({4{bt}});
                        exp_size.push_back(32'd0);
                    end else begin
                        ref_mem[addr[7:2]] = b;
                        exp_data.push_back(b);
                        exp_size.push_back(32'd2);
                    end
                end
                K_BRANCH: begin
                    wr = 1'b0;
                    if ((a == b) != p_f3[pc][0]) begin
                        next = pc + int'($signed(p_imm[pc])) / 4;
                    end
                end
                default: begin
                    res  = RESET_PC + word_t'(pc * 4 + 4);
                    next = pc + int'($signed(p_imm[pc])) / 4;
                end
            endcase
            if (wr && p_rd[pc] != 0) begin
                regs[p_rd[pc]] = res;
            end
            pc = next;
            steps++;
        end
    endfunction

    task automatic fill_memories();
        for (int i = 0; i < 64; i++) begin
            dmem[i]    = 32'h5a00_0000 ^ (word_t'(i) * 32'h0001_0203) ^ word_t'(i);
            ref_mem[i] = dmem[i];
        end
    endtask

    // random hold of 0 to 3 cycles after each transfer
    always @(negedge clk) begin
        if (!iready_n) begin
            ihold = random_mode ? ($random(seed) & 3) : 0;
        end
        i_next = (ihold != 0);
        if (ihold != 0) begin
            ihold--;
        end
        if (dreq && !dready_n && !dbusy) begin
            dhold = random_mode ? ($random(seed) & 3) : 0;
        end
        d_next = (dhold != 0);
        if (dhold != 0) begin
            dhold--;
        end
        // dbusy now and then in the random pass
        b_next = random_mode && (($random(seed) & 7) == 0);
    end

    always @(posedge clk) begin
        iready_n <= i_next;
        dready_n <= d_next;
        dbusy    <= b_next;
    end

    // store completes on the next rising edge
    always @(negedge clk) begin
        if (arst_n && dreq && dwrite && !dready_n && !dbusy) begin
            if (n_seen >= exp_addr.size()) begin
                $display("core wrote more stores than the program makes, at %h", daddr);
                $display("Simulation failed");
                $fatal(1);
            end
            check_value("store address", exp_addr[n_seen], daddr);
            check_value("store data", exp_data[n_seen], ddata);
            check_value("store size", exp_size[n_seen], word_t'(dsize));
            if (dsize == 2'b00) begin
                dmem[daddr[7:2]][daddr[1:0] * 8 +: 8] = ddata[daddr[1:0] * 8 +: 8];
            end else begin
                dmem[daddr[7:2]] = ddata;
            end
            n_seen++;
        end
    end

    initial begin
        seed        = 12052;
        arst_n      = 1'b0;
        iready_n    = 1'b1;
        dready_n    = 1'b1;
        dbusy       = 1'b0;
        i_next      = 1'b1;
        d_next      = 1'b1;
        b_next      = 1'b0;
        ihold       = 0;
        dhold       = 0;
        n_seen      = 0;
        random_mode = 1'b0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
        end
        build_program();
        for (int pass = 0; pass < 2; pass++) begin
            fill_memories();
            ref_run();
            @(posedge clk);
            n_seen      = 0;
            ihold       = 0;
            dhold       = 0;
            random_mode = (pass == 1);
            arst_n <= 1'b0;
            repeat (2) @(posedge clk);
            @(negedge clk);
            check_value("reset dreq", '0, word_t'(dreq));
            check_value("reset dwrite", '0, word_t'(dwrite));
            check_value("reset iaddr", RESET_PC, iaddr);
            @(posedge clk);
            arst_n <= 1'b1;
            cycles = 0;
            while (n_seen < exp_addr.size()) begin
                @(negedge clk);
                cycles++;
                if (cycles > 4000) begin
                    $display("core stopped storing after %0d of %0d stores",
                             n_seen, exp_addr.size());
                    $display("Simulation failed");
                    $fatal(1);
                end
            end
            // halt loop must stay quiet
            repeat (30) @(negedge clk);
            for (int i = 0; i < 64; i++) begin
                check_value("final memory", ref_mem[i], dmem[i]);
            end
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- rv_core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// five-stage RV32I subset core top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module rv_core #(
    parameter rv_core_pkg::word_t RESET_PC = '0
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    iready_n,
    input  rv_core_pkg::word_t      idata,
    output rv_core_pkg::word_t      iaddr,
    input  logic                    dready_n,
    input  logic                    dbusy,
    output rv_core_pkg::word_t      daddr,
    output logic [1:0]              dsize,
    output logic                    dreq,
    output logic                    dwrite,
    inout  wire rv_core_pkg::word_t ddata
);
    import rv_core_pkg::*;

    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    mem_wb_t   mem_wb;
    reg_addr_t rs1, rs2;
    word_t     rs1_data, rs2_data;
    word_t     ex_fwd_data, wb_fwd_data;
    word_t     redirect_pc, ddata_out;
    fwd_sel_e  fwd_a, fwd_b;
    logic      stall_if, stall_id, stall_all;
    logic      flush, mem_wait;

    // core drives the bus only for stores
    assign ddata = (dreq && dwrite) ? ddata_out : 'z;

    rv_fetch #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk         (clk),
        .arst_n      (arst_n),
        .stall_if    (stall_if),
        .flush       (flush),
        .redirect_pc (redirect_pc),
        .iready_n    (iready_n),
        .idata       (idata),
        .iaddr       (iaddr),
        .if_id       (if_id)
    );

    rv_decode u_decode (
        .clk         (clk),
        .arst_n      (arst_n),
        .stall_all   (stall_all),
        .stall_id    (stall_id),
        .flush       (flush),
        .if_id       (if_id),
        .rs1         (rs1),
        .rs2         (rs2),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b),
        .ex_fwd_data (ex_fwd_data),
        .wb_fwd_data (wb_fwd_data),
        .id_ex       (id_ex)
    );

    rv_execute u_execute (
        .clk         (clk),
        .arst_n      (arst_n),
        .stall_all   (stall_all),
        .id_ex       (id_ex),
        .flush       (flush),
        .redirect_pc (redirect_pc),
        .ex_fwd_data (ex_fwd_data),
        .ex_mem      (ex_mem)
    );

    rv_mem_access u_mem_access (
        .clk         (clk),
        .arst_n      (arst_n),
        .ex_mem      (ex_mem),
        .dready_n    (dready_n),
        .dbusy       (dbusy),
        .ddata_in    (ddata),
        .daddr       (daddr),
        .dsize       (dsize),
        .dreq        (dreq),
        .dwrite      (dwrite),
        .ddata_out   (ddata_out),
        .mem_wait    (mem_wait),
        .wb_fwd_data (wb_fwd_data),
        .mem_wb      (mem_wb)
    );

    rv_regfile u_regfile (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .mem_wb   (mem_wb)
    );

    rv_hazard_unit u_hazard_unit (
        .rs1       (rs1),
        .rs2       (rs2),
        .id_ex     (id_ex),
        .ex_mem    (ex_mem),
        .mem_wait  (mem_wait),
        .stall_if  (stall_if),
        .stall_id  (stall_id),
        .stall_all (stall_all),
        .fwd_a     (fwd_a),
        .fwd_b     (fwd_b)
    );

endmodule

//--- rv_hazard_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// forwarding select, load-use and bus stalls
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module rv_hazard_unit (
    input  rv_core_pkg::reg_addr_t rs1,
    input  rv_core_pkg::reg_addr_t rs2,
    input  rv_core_pkg::id_ex_t    id_ex,
    input  rv_core_pkg::ex_mem_t   ex_mem,
    input  logic                   mem_wait,
    output logic                   stall_if,
    output logic                   stall_id,
    output logic                   stall_all,
    output rv_core_pkg::fwd_sel_e  fwd_a,
    output rv_core_pkg::fwd_sel_e  fwd_b
);
    import rv_core_pkg::*;

    logic load_use;

    // nearest producer first
    function automatic fwd_sel_e pick_src(reg_addr_t rs, id_ex_t ex, ex_mem_t mem);
        if (rs == '0) begin
            return FWD_REG;
        end
        if (ex.valid && ex.reg_write && ex.rd == rs) begin
            return FWD_EXMEM;
        end
        if (mem.valid && mem.reg_write && mem.rd == rs) begin
            return FWD_MEMWB;
        end
        return FWD_REG;
    endfunction

    assign fwd_a = pick_src(rs1, id_ex, ex_mem);
    assign fwd_b = pick_src(rs2, id_ex, ex_mem);

    // load data exists only once the access is in memory stage
    assign load_use = id_ex.valid && id_ex.mem_read && (id_ex.rd != '0) &&
                      (id_ex.rd == rs1 || id_ex.rd == rs2);

    assign stall_all = mem_wait;
    assign stall_id  = load_use;
    assign stall_if  = load_use || mem_wait;

endmodule

//--- rv_mem_access.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data bus requests, byte lanes, MEM/WB register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module rv_mem_access (
    input  logic                 clk,
    input  logic                 arst_n,
    input  rv_core_pkg::ex_mem_t ex_mem,
    input  logic                 dready_n,
    input  logic                 dbusy,
    input  rv_core_pkg::word_t   ddata_in,
    output rv_core_pkg::word_t   daddr,
    output logic [1:0]           dsize,
    output logic                 dreq,
    output logic                 dwrite,
    output rv_core_pkg::word_t   ddata_out,
    output logic                 mem_wait,
    output rv_core_pkg::word_t   wb_fwd_data,
    output rv_core_pkg::mem_wb_t mem_wb
);
    import rv_core_pkg::*;

    logic       access;
    logic [7:0] lane;
    word_t      load_data;

    assign access    = ex_mem.valid && (ex_mem.mem_read || ex_mem.mem_write);
    assign dreq      = access;
    assign dwrite    = access && ex_mem.mem_write;
    assign daddr     = ex_mem.result;
    assign dsize     = ex_mem.mem_byte ? 2'b00 : 2'b10;
    // sb puts the byte on every lane
    assign ddata_out = ex_mem.mem_byte ? {4{ex_mem.store_data[7:0]}} : ex_mem.store_data;
    assign mem_wait  = access && (dready_n || dbusy);

    always_comb begin
        case (daddr[1:0])
            2'd0:    lane = ddata_in[7:0];
            2'd1:    lane = ddata_in[15:8];
            2'd2:    lane = ddata_in[23:16];
            default: lane = ddata_in[31:24];
        endcase
    end

    assign load_data = ex_mem.mem_byte ? {24'b0, lane} : ddata_in;

    assign wb_fwd_data = (ex_mem.wb_sel == WB_MEM) ? load_data :
                         (ex_mem.wb_sel == WB_PC4) ? ex_mem.pc_plus4 : ex_mem.result;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_wb <= '0;
        end else begin
            // bubble while the bus holds the access
            mem_wb.valid     <= ex_mem.valid && !mem_wait;
            mem_wb.rd        <= ex_mem.rd;
            mem_wb.reg_write <= ex_mem.reg_write;
            mem_wb.wb_data   <= wb_fwd_data;
        end
    end

endmodule

//--- rv_execute.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ALU, branch/jump resolution, EX/MEM register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module rv_execute (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 stall_all,
    input  rv_core_pkg::id_ex_t  id_ex,
    output logic                 flush,
    output rv_core_pkg::word_t   redirect_pc,
    output rv_core_pkg::word_t   ex_fwd_data,
    output rv_core_pkg::ex_mem_t ex_mem
);
    import rv_core_pkg::*;

    word_t a, b, alu_out, pc_plus4;
    logic  equal, taken;

    assign a        = id_ex.rs1_data;
    assign b        = id_ex.alu_use_imm ? id_ex.imm : id_ex.rs2_data;
    assign pc_plus4 = id_ex.pc + 32'd4;

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD:    alu_out = a + b;
            ALU_SUB:    alu_out = a - b;
            ALU_AND:    alu_out = a & b;
            ALU_OR:     alu_out = a | b;
            ALU_XOR:    alu_out = a ^ b;
            ALU_SLT:    alu_out = {31'b0, $signed(a) < $signed(b)};
            ALU_SLL:    alu_out = a << b[4:0];
            ALU_SRL:    alu_out = a >> b[4:0];
            ALU_PASS_B: alu_out = b;
            default:    alu_out = '0;
        endcase
    end

    // branch compares rs1 with rs2 and not the immediate
    assign equal       = (id_ex.rs1_data == id_ex.rs2_data);
    assign taken       = id_ex.is_branch && (id_ex.branch_ne ? !equal : equal);
    assign flush       = id_ex.valid && (taken || id_ex.is_jal);
    assign redirect_pc = id_ex.pc + id_ex.imm;

    // value this instruction will hand to decode next cycle
    assign ex_fwd_data = (id_ex.wb_sel == WB_PC4) ? pc_plus4 : alu_out;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem <= '0;
        end else if (!stall_all) begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.result     <= alu_out;
            ex_mem.store_data <= id_ex.rs2_data;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.reg_write  <= id_ex.reg_write;
            ex_mem.wb_sel     <= id_ex.wb_sel;
            ex_mem.mem_read   <= id_ex.mem_read;
            ex_mem.mem_write  <= id_ex.mem_write;
            ex_mem.mem_byte   <= id_ex.mem_byte;
            ex_mem.pc_plus4   <= pc_plus4;
        end
    end

endmodule

//--- rv_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction decode, immediates, operand select, ID/EX register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module rv_decode (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   stall_all,
    input  logic                   stall_id,
    input  logic                   flush,
    input  rv_core_pkg::if_id_t    if_id,
    output rv_core_pkg::reg_addr_t rs1,
    output rv_core_pkg::reg_addr_t rs2,
    input  rv_core_pkg::word_t     rs1_data,
    input  rv_core_pkg::word_t     rs2_data,
    input  rv_core_pkg::fwd_sel_e  fwd_a,
    input  rv_core_pkg::fwd_sel_e  fwd_b,
    input  rv_core_pkg::word_t     ex_fwd_data,
    input  rv_core_pkg::word_t     wb_fwd_data,
    output rv_core_pkg::id_ex_t    id_ex
);
    import rv_core_pkg::*;

    word_t      instr;
    logic [6:0] opcode;
    logic [2:0] funct3;
    word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
    word_t      op_a, op_b;
    logic       legal;
    id_ex_t     dec;

    assign instr  = if_id.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // operands from the stage ahead win over the register file
    assign op_a = (fwd_a == FWD_EXMEM) ? ex_fwd_data :
                  (fwd_a == FWD_MEMWB) ? wb_fwd_data : rs1_data;
    assign op_b = (fwd_b == FWD_EXMEM) ? ex_fwd_data :
                  (fwd_b == FWD_MEMWB) ? wb_fwd_data : rs2_data;

    always_comb begin
        legal        = 1'b1;
        dec          = '0;
        dec.pc       = if_id.pc;
        dec.rs1_data = op_a;
        dec.rs2_data = op_b;
        dec.rd       = instr[11:7];
        dec.rs1      = rs1;
        dec.rs2      = rs2;
        dec.alu_op   = ALU_ADD;
        dec.wb_sel   = WB_ALU;
        case (opcode)
            OP_REG, OP_IMM: begin
                dec.reg_write   = 1'b1;
                dec.alu_use_imm = (opcode == OP_IMM);
                dec.imm         = imm_i;
                case (funct3)
                    F3_ADD: dec.alu_op = (opcode == OP_REG && instr[30]) ? ALU_SUB : ALU_ADD;
                    F3_SLL: dec.alu_op = ALU_SLL;
                    F3_SLT: dec.alu_op = ALU_SLT;
                    F3_XOR: dec.alu_op = ALU_XOR;
                    F3_OR:  dec.alu_op = ALU_OR;
                    F3_AND: dec.alu_op = ALU_AND;
                    F3_SRL: begin
                        // sra is outside the subset
                        dec.alu_op = ALU_SRL;
                        legal      = !instr[30];
                    end
                    default: legal = 1'b0;
                endcase
            end
            OP_LUI: begin
                dec.reg_write   = 1'b1;
                dec.alu_use_imm = 1'b1;
                dec.imm         = imm_u;
                dec.alu_op      = ALU_PASS_B;
            end
            OP_LOAD: begin
                dec.reg_write   = 1'b1;
                dec.alu_use_imm = 1'b1;
                dec.imm         = imm_i;
                dec.mem_read    = 1'b1;
                dec.wb_sel      = WB_MEM;
                dec.mem_byte    = (funct3 == F3_BYTEU);
                legal           = (funct3 == F3_WORD) || (funct3 == F3_BYTEU);
            end
            OP_STORE: begin
                dec.alu_use_imm = 1'b1;
                dec.imm         = imm_s;
                dec.mem_write   = 1'b1;
                dec.mem_byte    = (funct3 == F3_BYTE);
                legal           = (funct3 == F3_WORD) || (funct3 == F3_BYTE);
            end
            OP_BRANCH: begin
                dec.imm       = imm_b;
                dec.is_branch = 1'b1;
                dec.branch_ne = (funct3 == F3_BNE);
                legal         = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
            end
            OP_JAL: begin
                dec.imm       = imm_j;
                dec.is_jal    = 1'b1;
                dec.reg_write = 1'b1;
                dec.wb_sel    = WB_PC4;
            end
            default: legal = 1'b0;
        endcase
        // unknown encodings fall through as a no-op
        dec.valid = if_id.valid && legal;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_ex <= '0;
        end else if (!stall_all) begin
            if (flush || stall_id) begin
                id_ex <= '0;
            end else begin
                id_ex <= dec;
            end
        end
    end

endmodule

//--- rv_fetch.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// program counter, instruction request, IF/ID register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module rv_fetch #(
    parameter rv_core_pkg::word_t RESET_PC = '0
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                stall_if,
    input  logic                flush,
    input  rv_core_pkg::word_t  redirect_pc,
    input  logic                iready_n,
    input  rv_core_pkg::word_t  idata,
    output rv_core_pkg::word_t  iaddr,
    output rv_core_pkg::if_id_t if_id
);
    import rv_core_pkg::*;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            iaddr <= RESET_PC;
            if_id <= '0;
        end else if (!stall_if) begin
            if (flush) begin
                iaddr       <= redirect_pc;
                if_id.valid <= 1'b0;
            end else if (iready_n) begin
                // PC waits for the instruction
                if_id.valid <= 1'b0;
            end else begin
                iaddr <= iaddr + 32'd4;
                if_id <= '{valid: 1'b1, pc: iaddr, instr: idata};
            end
        end
    end

endmodule

//--- rv_regfile.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 32 x 32 register file, two read ports, one write port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module rv_regfile (
    input  logic                  clk,
    input  logic                  arst_n,
    input  rv_core_pkg::reg_addr_t rs1,
    input  rv_core_pkg::reg_addr_t rs2,
    output rv_core_pkg::word_t    rs1_data,
    output rv_core_pkg::word_t    rs2_data,
    input  rv_core_pkg::mem_wb_t  mem_wb
);
    import rv_core_pkg::*;

    word_t regs [32];
    logic  we;

    assign we = mem_wb.valid && mem_wb.reg_write && (mem_wb.rd != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[mem_wb.rd] <= mem_wb.wb_data;
        end
    end

    // write in the same cycle passes straight through
    assign rs1_data = (rs1 == '0) ? '0 :
                      (we && mem_wb.rd == rs1) ? mem_wb.wb_data : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 :
                      (we && mem_wb.rd == rs2) ? mem_wb.wb_data : regs[rs2];

endmodule

//--- rv_core_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// opcodes, function codes, ALU and forwarding enums
// and pipeline structs of the RV32I subset core
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package rv_core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    // funct3 for ALU ops
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SRL = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // funct3 for memory and branch ops
    localparam logic [2:0] F3_BYTE  = 3'b000;
    localparam logic [2:0] F3_WORD  = 3'b010;
    localparam logic [2:0] F3_BYTEU = 3'b100;
    localparam logic [2:0] F3_BEQ   = 3'b000;
    localparam logic [2:0] F3_BNE   = 3'b001;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLL, ALU_SRL, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {FWD_REG, FWD_EXMEM, FWD_MEMWB} fwd_sel_e;
    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_sel_e;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        alu_op_e   alu_op;
        logic      alu_use_imm;
        logic      reg_write;
        wb_sel_e   wb_sel;
        logic      mem_read;
        logic      mem_write;
        logic      mem_byte;
        logic      is_branch;
        logic      branch_ne;
        logic      is_jal;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        word_t     result;
        word_t     store_data;
        reg_addr_t rd;
        logic      reg_write;
        wb_sel_e   wb_sel;
        logic      mem_read;
        logic      mem_write;
        logic      mem_byte;
        word_t     pc_plus4;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        logic      reg_write;
        word_t     wb_data;
    } mem_wb_t;

endpackage
